/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

    localparam int DATA_BITS     = 8;
    localparam int TICKS_PER_BIT = 16;  // Oversampling factor

endpackage

`default_nettype wire

/* debug_pkg.sv */
`default_nettype none

package debug_pkg;

    localparam logic [7:0] CMD_DUMP_REGS       = 8'h01;
    localparam logic [7:0] CMD_DUMP_IF_ID      = 8'h02;
    localparam logic [7:0] CMD_LOAD_PROGRAM    = 8'h07;
    localparam logic [7:0] CMD_MODE_CONTINUOUS = 8'h08;
    localparam logic [7:0] CMD_MODE_STEP       = 8'h09;
    localparam logic [7:0] CMD_STEP            = 8'h0A;
    localparam logic [7:0] CMD_DUMP_PC         = 8'h11;

    localparam logic [7:0] ACK_CHAR = "R";

    localparam int WORD_BITS         = 32;  // Processor word width
    localparam int IF_ID_BITS        = 64;
    localparam int PROG_RESET_CYCLES = 16;

    typedef enum logic [1:0] {
        DUMP_REGS,
        DUMP_IF_ID,
        DUMP_PC,
        DUMP_ACK      // No payload, ACK only
    } dump_src_t;

    // Program word as it arrives from the host and as it goes to memory
    typedef union packed {
        logic [WORD_BITS/8-1:0][7:0] bytes;  // Index 0 arrives first
        logic [WORD_BITS-1:0]        word;
    } instr_word_t;

endpackage

`default_nettype wire

/* baud_tick_gen.sv */
`default_nettype none

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = 163
) (
    input  wire  i_clk,
    input  wire  i_reset,
    output logic o_tick
);

    localparam int CNT_W = $clog2(CLKS_PER_TICK + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt == CNT_W'(CLKS_PER_TICK - 1)) begin
            cnt    <= '0;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx (
    input  wire                            i_clk,
    input  wire                            i_reset,
    input  wire                            i_tick,
    input  wire                            i_rx,
    output logic [uart_pkg::DATA_BITS-1:0] o_rx_data,
    output logic                           o_rx_valid
);
    import uart_pkg::*;

    localparam int TICK_W = $clog2(TICKS_PER_BIT);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t                    state;
    logic [1:0]                   rx_sync;   // Line synchronizer
    logic [TICK_W-1:0]            tick_cnt;
    logic [$clog2(DATA_BITS)-1:0] bit_cnt;
    logic                         bit_mid;

    assign bit_mid = i_tick && (tick_cnt == TICK_W'(TICKS_PER_BIT - 1));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_sync    <= 2'b11;
            state      <= RX_IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], i_rx};
            o_rx_valid <= 1'b0;
            if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (i_tick && tick_cnt == TICK_W'(TICKS_PER_BIT / 2 - 1)) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == DATA_BITS - 1) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_mid) begin
                        o_rx_valid <= rx_sync[1];  // Framing error drops the byte
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_mid) begin
            o_rx_data <= {rx_sync[1], o_rx_data[DATA_BITS-1:1]};  // LSB first
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

module uart_tx (
    input  wire                           i_clk,
    input  wire                           i_reset,
    input  wire                           i_tick,
    input  wire                           i_tx_start,
    input  wire [uart_pkg::DATA_BITS-1:0] i_tx_data,
    output logic                          o_tx,
    output logic                          o_tx_busy
);
    import uart_pkg::*;

    localparam int TICK_W = $clog2(TICKS_PER_BIT);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t                    state;
    logic [TICK_W-1:0]            tick_cnt;
    logic [$clog2(DATA_BITS)-1:0] bit_cnt;
    logic [DATA_BITS-1:0]         shreg;
    logic                         bit_end;

    assign bit_end   = i_tick && (tick_cnt == TICK_W'(TICKS_PER_BIT - 1));
    assign o_tx_busy = (state != TX_IDLE);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_tx     <= 1'b1;
        end else begin
            o_tx <= (state == TX_START) ? 1'b0 : (state == TX_DATA) ? shreg[0] : 1'b1;
            if (state == TX_IDLE || bit_end) begin
                tick_cnt <= '0;
            end else if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                TX_IDLE:  if (i_tx_start) state <= TX_START;
                TX_START: begin
                    bit_cnt <= '0;
                    if (bit_end) state <= TX_DATA;
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == DATA_BITS - 1) state <= TX_STOP;
                    end
                end
                TX_STOP:  if (bit_end) state <= TX_IDLE;
                default:  state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_tx_start) begin
            shreg <= i_tx_data;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

/* snapshot_sender.sv */
`default_nettype none

module snapshot_sender #(
    parameter int NUM_REGISTERS = 32
) (
    input  wire                                          i_clk,
    input  wire                                          i_reset,
    input  wire                                          i_dump_start,
    input  wire debug_pkg::dump_src_t                    i_dump_src,
    input  wire [debug_pkg::WORD_BITS*NUM_REGISTERS-1:0] i_registers,
    input  wire [debug_pkg::IF_ID_BITS-1:0]              i_if_id,
    input  wire [debug_pkg::WORD_BITS-1:0]               i_pc,
    input  wire                                          i_tx_busy,
    output logic                                         o_tx_start,
    output logic [7:0]                                   o_tx_data,
    output logic                                         o_dump_done
);
    import debug_pkg::*;

    localparam int REG_BYTES   = WORD_BITS / 8 * NUM_REGISTERS;
    localparam int IDX_W       = $clog2(REG_BYTES + IF_ID_BITS / 8 + 1);
    localparam int REG_IDX_W   = $clog2(REG_BYTES);
    localparam int IF_ID_IDX_W = $clog2(IF_ID_BITS / 8);
    localparam int PC_IDX_W    = $clog2(WORD_BITS / 8);

    dump_src_t        src;
    logic             active;
    logic [IDX_W-1:0] idx;        // Byte being offered to the transmitter
    logic [IDX_W-1:0] limit;      // Payload length and index of the ACK
    logic [7:0]       snap_byte;

    always_comb begin
        limit     = '0;
        snap_byte = i_pc[8*idx[PC_IDX_W-1:0] +: 8];
        case (src)
            DUMP_REGS: begin
                limit     = IDX_W'(REG_BYTES);
                snap_byte = i_registers[8*idx[REG_IDX_W-1:0] +: 8];
            end
            DUMP_IF_ID: begin
                limit     = IDX_W'(IF_ID_BITS / 8);
                snap_byte = i_if_id[8*idx[IF_ID_IDX_W-1:0] +: 8];
            end
            DUMP_PC:  limit = IDX_W'(WORD_BITS / 8);
            default:  limit = '0;
        endcase
    end

    assign o_tx_data  = (idx == limit) ? ACK_CHAR : snap_byte;
    assign o_tx_start = active && !i_tx_busy;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            active      <= 1'b0;
            src         <= DUMP_ACK;
            idx         <= '0;
            o_dump_done <= 1'b0;
        end else begin
            o_dump_done <= 1'b0;
            if (!active && i_dump_start) begin
                active <= 1'b1;
                src    <= i_dump_src;
                idx    <= '0;
            end else if (o_tx_start) begin
                if (idx == limit) begin
                    active      <= 1'b0;
                    o_dump_done <= 1'b1;  // ACK handed to the transmitter
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* program_loader.sv */
`default_nettype none

module program_loader #(
    parameter int MEM_WORDS = 64
) (
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire                             i_load_start,
    input  wire [7:0]                       i_rx_data,
    input  wire                             i_rx_valid,
    output logic                            o_inst_wr_en,
    output logic [$clog2(MEM_WORDS)-1:0]    o_inst_wr_addr,
    output logic [debug_pkg::WORD_BITS-1:0] o_inst_wr_data,
    output logic                            o_prog_reset,
    output logic                            o_load_done
);
    import debug_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(MEM_WORDS - 1);

    typedef enum logic [2:0] {
        LD_IDLE, LD_COUNT, LD_BYTES, LD_FILL, LD_RESET, LD_DONE
    } ld_state_t;

    ld_state_t                            state;
    instr_word_t                          word;
    logic [1:0]                           byte_idx;
    logic [7:0]                           word_total;  // N sent by the host
    logic [7:0]                           word_cnt;
    logic [$clog2(PROG_RESET_CYCLES)-1:0] rst_cnt;

    assign o_inst_wr_data = (state == LD_FILL) ? '0 : word.word;
    assign o_load_done    = (state == LD_DONE);

    always_ff @(posedge i_clk) begin
        if (state == LD_BYTES && i_rx_valid) begin
            word.bytes[byte_idx] <= i_rx_data;  // Little-endian
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state          <= LD_IDLE;
            byte_idx       <= '0;
            word_total     <= '0;
            word_cnt       <= '0;
            rst_cnt        <= '0;
            o_inst_wr_en   <= 1'b0;
            o_inst_wr_addr <= '0;
            o_prog_reset   <= 1'b0;
        end else begin
            o_inst_wr_en <= 1'b0;
            if (o_inst_wr_en) begin
                o_inst_wr_addr <= o_inst_wr_addr + 1'b1;
            end
            case (state)
                LD_IDLE: if (i_load_start) state <= LD_COUNT;
                LD_COUNT: begin
                    byte_idx       <= '0;
                    word_cnt       <= '0;
                    rst_cnt        <= '0;
                    o_inst_wr_addr <= '0;
                    if (i_rx_valid) begin
                        word_total   <= i_rx_data;
                        o_inst_wr_en <= (i_rx_data == 8'd0);  // Empty program goes straight to fill
                        state        <= (i_rx_data == 8'd0) ? LD_FILL : LD_BYTES;
                    end
                end
                LD_BYTES: begin
                    if (i_rx_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            o_inst_wr_en <= 1'b1;
                            word_cnt     <= word_cnt + 1'b1;
                        end
                    end
                    if (o_inst_wr_en && word_cnt == word_total) begin
                        if (o_inst_wr_addr == LAST_ADDR) begin
                            o_prog_reset <= 1'b1;
                            state        <= LD_RESET;
                        end else begin
                            o_inst_wr_en <= 1'b1;
                            state        <= LD_FILL;
                        end
                    end
                end
                LD_FILL: begin
                    if (o_inst_wr_addr == LAST_ADDR) begin
                        o_prog_reset <= 1'b1;
                        state        <= LD_RESET;
                    end else begin
                        o_inst_wr_en <= 1'b1;
                    end
                end
                LD_RESET: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == PROG_RESET_CYCLES - 1) begin
                        o_prog_reset <= 1'b0;
                        state        <= LD_DONE;
                    end
                end
                LD_DONE:  state <= LD_IDLE;
                default:  state <= LD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* debug_controller.sv */
`default_nettype none

module debug_controller (
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire [7:0]            i_rx_data,
    input  wire                  i_rx_valid,
    input  wire                  i_dump_done,
    input  wire                  i_load_done,
    output logic                 o_dump_start,
    output debug_pkg::dump_src_t o_dump_src,
    output logic                 o_load_start,
    output logic                 o_debug_clk
);
    import debug_pkg::*;

    typedef enum logic [1:0] {CTL_IDLE, CTL_WAIT_DUMP, CTL_WAIT_LOAD} ctl_state_t;

    ctl_state_t state;
    logic       step_mode;  // 1 = step, 0 = continuous
    logic       step_req;
    logic       step_clk;

    assign o_debug_clk = step_mode ? step_clk : i_clk;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= CTL_IDLE;
            step_mode    <= 1'b0;
            step_req     <= 1'b0;
            step_clk     <= 1'b0;
            o_dump_start <= 1'b0;
            o_dump_src   <= DUMP_ACK;
            o_load_start <= 1'b0;
        end else begin
            o_dump_start <= 1'b0;
            o_load_start <= 1'b0;
            step_req     <= 1'b0;
            step_clk     <= step_req;  // One full clock period high
            case (state)
                CTL_IDLE: begin
                    if (i_rx_valid) begin
                        case (i_rx_data)
                            CMD_DUMP_REGS, CMD_DUMP_IF_ID, CMD_DUMP_PC: begin
                                o_dump_start <= 1'b1;
                                o_dump_src   <= (i_rx_data == CMD_DUMP_REGS)  ? DUMP_REGS :
                                                (i_rx_data == CMD_DUMP_IF_ID) ? DUMP_IF_ID :
                                                DUMP_PC;
                                state        <= CTL_WAIT_DUMP;
                            end
                            CMD_LOAD_PROGRAM: begin
                                o_load_start <= 1'b1;
                                step_mode    <= 1'b1;  // Processor stays parked while loading
                                state        <= CTL_WAIT_LOAD;
                            end
                            CMD_MODE_CONTINUOUS: step_mode <= 1'b0;
                            CMD_MODE_STEP:       step_mode <= 1'b1;
                            CMD_STEP:            step_req  <= 1'b1;
                            default:             state     <= CTL_IDLE;
                        endcase
                    end
                end
                CTL_WAIT_DUMP: if (i_dump_done) state <= CTL_IDLE;
                CTL_WAIT_LOAD: begin
                    if (i_load_done) begin
                        o_dump_start <= 1'b1;
                        o_dump_src   <= DUMP_ACK;
                        state        <= CTL_WAIT_DUMP;
                    end
                end
                default: state <= CTL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* debug_unit.sv */
`default_nettype none

module debug_unit #(
    parameter int CLKS_PER_TICK = 163,
    parameter int NUM_REGISTERS = 32,
    parameter int MEM_WORDS     = 64
) (
    input  wire                                          i_clk,
    input  wire                                          i_reset,
    input  wire                                          i_uart_rx,
    input  wire [debug_pkg::WORD_BITS*NUM_REGISTERS-1:0] i_registers,
    input  wire [debug_pkg::IF_ID_BITS-1:0]              i_if_id,
    input  wire [debug_pkg::WORD_BITS-1:0]               i_pc,
    output logic                                         o_uart_tx,
    output logic                                         o_debug_clk,
    output logic                                         o_inst_wr_en,
    output logic [$clog2(MEM_WORDS)-1:0]                 o_inst_wr_addr,
    output logic [debug_pkg::WORD_BITS-1:0]              o_inst_wr_data,
    output logic                                         o_prog_reset
);
    import debug_pkg::*;

    logic       tick;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       dump_start;
    dump_src_t  dump_src;
    logic       dump_done;
    logic       load_start;
    logic       load_done;

    baud_tick_gen #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_baud (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_rx (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_tick     (tick),
        .i_rx       (i_uart_rx),
        .o_rx_data  (rx_data),
        .o_rx_valid (rx_valid)
    );

    uart_tx u_tx (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx       (o_uart_tx),
        .o_tx_busy  (tx_busy)
    );

    snapshot_sender #(.NUM_REGISTERS(NUM_REGISTERS)) u_sender (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_dump_start (dump_start),
        .i_dump_src   (dump_src),
        .i_registers  (i_registers),
        .i_if_id      (i_if_id),
        .i_pc         (i_pc),
        .i_tx_busy    (tx_busy),
        .o_tx_start   (tx_start),
        .o_tx_data    (tx_data),
        .o_dump_done  (dump_done)
    );

    program_loader #(.MEM_WORDS(MEM_WORDS)) u_loader (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_load_start   (load_start),
        .i_rx_data      (rx_data),
        .i_rx_valid     (rx_valid),
        .o_inst_wr_en   (o_inst_wr_en),
        .o_inst_wr_addr (o_inst_wr_addr),
        .o_inst_wr_data (o_inst_wr_data),
        .o_prog_reset   (o_prog_reset),
        .o_load_done    (load_done)
    );

    debug_controller u_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_data    (rx_data),
        .i_rx_valid   (rx_valid),
        .i_dump_done  (dump_done),
        .i_load_done  (load_done),
        .o_dump_start (dump_start),
        .o_dump_src   (dump_src),
        .o_load_start (load_start),
        .o_debug_clk  (o_debug_clk)
    );

endmodule

`default_nettype wire

/* debug_unit_checker.sv */
`default_nettype none

module debug_unit_checker #(
    parameter int MEM_WORDS = 64
) (
    input wire                         i_clk,
    input wire                         i_reset,
    input wire                         i_tx_start,
    input wire                         i_tx_busy,
    input wire                         i_inst_wr_en,
    input wire [$clog2(MEM_WORDS)-1:0] i_inst_wr_addr,
    input wire                         i_prog_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    import debug_pkg::*;

    int fail_count = 0;  // Read by the testbench at the end of the run

    a_tx_start_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tx_start |-> !i_tx_busy)
        else begin
            fail_count++;
            $error("tx start while the transmitter is busy");
        end

    a_prog_reset_len: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_prog_reset) |-> i_prog_reset [*PROG_RESET_CYCLES] ##1 !i_prog_reset)
        else begin
            fail_count++;
            $error("program reset high period has the wrong length");
        end

    a_wr_addr_range: assert property (@(posedge i_clk) disable iff (i_reset)
        i_inst_wr_en |-> (i_inst_wr_addr < MEM_WORDS))
        else begin
            fail_count++;
            $error("instruction write address out of range");
        end

    a_wr_not_in_reset: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_inst_wr_en && i_prog_reset))
        else begin
            fail_count++;
            $error("instruction write during program reset");
        end

endmodule

bind debug_unit debug_unit_checker #(.MEM_WORDS(MEM_WORDS)) u_checker (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_tx_start     (tx_start),
    .i_tx_busy      (tx_busy),
    .i_inst_wr_en   (o_inst_wr_en),
    .i_inst_wr_addr (o_inst_wr_addr),
    .i_prog_reset   (o_prog_reset)
);

`default_nettype wire

/* tb_debug_unit.sv */
`default_nettype none

module tb_debug_unit;
    timeunit 1ns;
    timeprecision 1ps;

    import debug_pkg::*;

    localparam int CLKS_PER_TICK = 2;
    localparam int NUM_REGISTERS = 4;
    localparam int MEM_WORDS     = 16;
    localparam int CLKS_PER_BIT  = 32;    // Host line rate
    localparam int RX_TIMEOUT    = 8000;  // Cycles to wait for a reply start bit
    localparam int QUIET_CYCLES  = 3 * CLKS_PER_BIT;
    localparam int NUM_ENTRIES   = 9;
    localparam int MAX_PAYLOAD   = 13;
    localparam int MAX_REPLY     = 17;

    localparam int DBG_NONE   = 0;
    localparam int DBG_FOLLOW = 1;  // o_debug_clk equals i_clk
    localparam int DBG_LOW    = 2;
    localparam int DBG_STEP   = 3;  // Exactly one high cycle

    logic                                i_clk = 1'b0;
    logic                                i_reset;
    logic                                i_uart_rx;
    logic [WORD_BITS*NUM_REGISTERS-1:0]  i_registers;
    logic [IF_ID_BITS-1:0]               i_if_id;
    logic [WORD_BITS-1:0]                i_pc;
    wire                                 o_uart_tx;
    wire                                 o_debug_clk;
    wire                                 o_inst_wr_en;
    wire  [$clog2(MEM_WORDS)-1:0]        o_inst_wr_addr;
    wire  [WORD_BITS-1:0]                o_inst_wr_data;
    wire                                 o_prog_reset;

    logic [7:0]           cmd_tab     [NUM_ENTRIES];
    int                   n_payload   [NUM_ENTRIES];
    logic [7:0]           payload_tab [NUM_ENTRIES][MAX_PAYLOAD];
    int                   n_reply     [NUM_ENTRIES];
    logic [7:0]           reply_tab   [NUM_ENTRIES][MAX_REPLY];
    logic                 load_tab    [NUM_ENTRIES];
    int                   dbg_tab     [NUM_ENTRIES];
    logic [WORD_BITS-1:0] prog_words  [MEM_WORDS];  // Memory image after the load

    int                           cyc = 0;
    int                           dbg_high = 0;
    int                           dbg_mismatch = 0;
    int                           rst_len = 0;
    int                           rst_fall_cyc = 0;
    logic [$clog2(MEM_WORDS)-1:0] wr_addr_q [$];
    logic [WORD_BITS-1:0]         wr_data_q [$];
    int                           rst_len_q [$];

    debug_unit #(
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .NUM_REGISTERS (NUM_REGISTERS),
        .MEM_WORDS     (MEM_WORDS)
    ) UUT (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_uart_rx      (i_uart_rx),
        .i_registers    (i_registers),
        .i_if_id        (i_if_id),
        .i_pc           (i_pc),
        .o_uart_tx      (o_uart_tx),
        .o_debug_clk    (o_debug_clk),
        .o_inst_wr_en   (o_inst_wr_en),
        .o_inst_wr_addr (o_inst_wr_addr),
        .o_inst_wr_data (o_inst_wr_data),
        .o_prog_reset   (o_prog_reset)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) cyc++;

    // Half-cycle samples of the processor clock
    always begin
        @(i_clk);
        #5;
        if (o_debug_clk === 1'b1) dbg_high++;
        if (o_debug_clk !== i_clk) dbg_mismatch++;
    end

    always @(negedge i_clk) begin
        if (o_inst_wr_en === 1'b1) begin
            wr_addr_q.push_back(o_inst_wr_addr);
            wr_data_q.push_back(o_inst_wr_data);
        end
        if (o_prog_reset === 1'b1) begin
            rst_len++;
        end else if (rst_len != 0) begin
            rst_len_q.push_back(rst_len);
            rst_fall_cyc = cyc;
            rst_len      = 0;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("** Error at %0d ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, expected));
        end
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, data, 1'b0};  // Stop, data LSB first, start
        for (i = 0; i < 10; i++) begin
            @(posedge i_clk);
            #1;
            i_uart_rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge i_clk);
        end
    endtask

    task automatic receive_byte(output logic [7:0] data, output int start_cyc);
        int t;
        int i;
        t = 0;
        @(negedge i_clk);
        while (o_uart_tx !== 1'b0) begin
            if (t == RX_TIMEOUT) abort_run("Timed out waiting for a reply byte from the DUT");
            t++;
            @(negedge i_clk);
        end
        start_cyc = cyc;
        repeat (CLKS_PER_BIT / 2) @(negedge i_clk);  // Middle of the start bit
        check_value("o_uart_tx start bit", o_uart_tx, 0);
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge i_clk);
            data[i] = o_uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        check_value("o_uart_tx stop bit", o_uart_tx, 1);
    endtask

    task automatic watch_quiet();
        repeat (QUIET_CYCLES) begin
            @(negedge i_clk);
            if (o_uart_tx !== 1'b1) abort_run("The DUT sent a byte where no reply was expected");
        end
    endtask

    task automatic set_entry(input int e, input logic [7:0] cmd, input int dbg);
        cmd_tab[e]   = cmd;
        n_payload[e] = 0;
        n_reply[e]   = 0;
        load_tab[e]  = 1'b0;
        dbg_tab[e]   = dbg;
    endtask

    task automatic add_payload(input int e, input logic [7:0] b);
        payload_tab[e][n_payload[e]] = b;
        n_payload[e]++;
    endtask

    task automatic add_reply(input int e, input logic [7:0] b);
        reply_tab[e][n_reply[e]] = b;
        n_reply[e]++;
    endtask

    task automatic build_table();
        instr_word_t w;
        logic [7:0]  b;
        int          k;
        int          n;
        set_entry(0, CMD_DUMP_REGS, DBG_NONE);
        for (k = 0; k < 4 * NUM_REGISTERS; k++) add_reply(0, i_registers[8*k +: 8]);
        add_reply(0, ACK_CHAR);
        set_entry(1, CMD_DUMP_IF_ID, DBG_NONE);
        for (k = 0; k < 8; k++) add_reply(1, i_if_id[8*k +: 8]);
        add_reply(1, ACK_CHAR);
        set_entry(2, CMD_DUMP_PC, DBG_NONE);
        add_payload(2, CMD_DUMP_IF_ID);  // Arrives mid-dump and must be dropped
        for (k = 0; k < 4; k++) add_reply(2, i_pc[8*k +: 8]);
        add_reply(2, ACK_CHAR);
        set_entry(3, 8'h5A, DBG_NONE);
        set_entry(4, CMD_LOAD_PROGRAM, DBG_LOW);
        load_tab[4] = 1'b1;
        add_payload(4, 8'd3);
        for (n = 0; n < MEM_WORDS; n++) prog_words[n] = '0;
        for (n = 0; n < 3; n++) begin
            for (k = 0; k < 4; k++) begin
                b = 8'($urandom);
                add_payload(4, b);
                w.bytes[k] = b;
            end
            prog_words[n] = w.word;
        end
        add_reply(4, ACK_CHAR);
        set_entry(5, CMD_STEP, DBG_STEP);  // Load left the clock in step mode
        set_entry(6, CMD_MODE_CONTINUOUS, DBG_FOLLOW);
        set_entry(7, CMD_MODE_STEP, DBG_LOW);
        set_entry(8, CMD_STEP, DBG_STEP);
    endtask

    task automatic apply_entry(input int e);
        logic [7:0] got;
        int         start_cyc;
        int         last_start;
        int         high_start;
        int         high_quiet;
        int         mism_quiet;
        int         i;
        int         j;
        wr_addr_q.delete();
        wr_data_q.delete();
        rst_len_q.delete();
        high_start = dbg_high;
        last_start = 0;
        fork
            begin
                send_byte(cmd_tab[e]);
                for (i = 0; i < n_payload[e]; i++) send_byte(payload_tab[e][i]);
            end
            begin
                for (j = 0; j < n_reply[e]; j++) begin
                    receive_byte(got, start_cyc);
                    check_value($sformatf("o_uart_tx reply byte %0d", j), got, reply_tab[e][j]);
                    last_start = start_cyc;
                end
            end
        join
        high_quiet = dbg_high;
        mism_quiet = dbg_mismatch;
        watch_quiet();
        if (load_tab[e]) begin
            check_value("o_inst_wr_en count", wr_addr_q.size(), MEM_WORDS);
            for (i = 0; i < MEM_WORDS; i++) begin
                check_value("o_inst_wr_addr", wr_addr_q[i], i);
                check_value("o_inst_wr_data", wr_data_q[i], prog_words[i]);
            end
            check_value("o_prog_reset pulses", rst_len_q.size(), 1);
            check_value("o_prog_reset length", rst_len_q[0], PROG_RESET_CYCLES);
            if (rst_fall_cyc >= last_start) abort_run("ACK started before program reset ended");
        end else begin
            check_value("o_inst_wr_en count", wr_addr_q.size(), 0);
            check_value("o_prog_reset pulses", rst_len_q.size(), 0);
        end
        case (dbg_tab[e])
            DBG_FOLLOW: check_value("o_debug_clk mismatches", dbg_mismatch - mism_quiet, 0);
            DBG_LOW:    check_value("o_debug_clk high samples", dbg_high - high_quiet, 0);
            DBG_STEP:   check_value("o_debug_clk high samples", dbg_high - high_start, 2);
            default:    ;
        endcase
    endtask

    initial begin
        int k;
        void'($urandom(32'h142));
        i_reset   = 1'b1;
        i_uart_rx = 1'b1;  // Line idles high
        for (k = 0; k < NUM_REGISTERS; k++) i_registers[32*k +: 32] = $urandom;
        i_if_id = {$urandom, $urandom};
        i_pc    = $urandom;
        build_table();
        repeat (8) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        repeat (4) @(posedge i_clk);
        for (k = 0; k < NUM_ENTRIES; k++) apply_entry(k);
        if (UUT.u_checker.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("A bound assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

/* debug_unit.f */
uart_pkg.sv
debug_pkg.sv
baud_tick_gen.sv
uart_rx.sv
uart_tx.sv
snapshot_sender.sv
program_loader.sv
debug_controller.sv
debug_unit.sv
debug_unit_checker.sv
tb_debug_unit.sv

/* Bender.yml */
package:
  name: debug_unit

sources:
  - uart_pkg.sv
  - debug_pkg.sv
  - baud_tick_gen.sv
  - uart_rx.sv
  - uart_tx.sv
  - snapshot_sender.sv
  - program_loader.sv
  - debug_controller.sv
  - debug_unit.sv
  - target: test
    files:
      - debug_unit_checker.sv
      - tb_debug_unit.sv
